// File: csr_file.f
hdl/csr_pkg.sv
hdl/csr_bus_if.sv
hdl/csr_access.sv
hdl/csr_trap_regs.sv
hdl/csr_counters.sv
hdl/csr_file.sv
sim/csr_file_properties.sv
sim/csr_file_tb.sv

// File: hdl/csr_access.sv
`default_nettype none

module csr_access #(
    parameter csr_pkg::csr_word_t HART_ID = 32'd0
) (
    input  logic                stall,
    input  logic                flush,
    input  logic                write,
    input  csr_pkg::csr_op_e    op,
    input  csr_pkg::csr_src_e   src,
    input  csr_pkg::csr_addr_t  csr,
    input  csr_pkg::csr_word_t  rs1_value,
    input  csr_pkg::csr_word_t  imm_value,
    output csr_pkg::csr_word_t  read_value,
    csr_bus_if.access           bus
);

    csr_pkg::csr_word_t operand;
    csr_pkg::csr_word_t const_value;
    csr_pkg::csr_word_t new_value;

    assign operand = (src == csr_pkg::csr_src_reg) ? rs1_value : imm_value;

    // constant part of the address map
    always_comb begin
        case (csr) inside
            csr_pkg::csr_misa: begin
                const_value = csr_pkg::misa_value;
            end
            csr_pkg::csr_mhartid: begin
                const_value = HART_ID;
            end
            csr_pkg::csr_mvendorid,
            csr_pkg::csr_marchid,
            csr_pkg::csr_mimpid,
            csr_pkg::csr_mip: begin
                const_value = '0;  // mip has no pending sources yet
            end
            [csr_pkg::csr_mhpmevent_base : csr_pkg::csr_mhpmevent_limit],
            [csr_pkg::csr_pmpcfg_base : csr_pkg::csr_pmpcfg_limit],
            [csr_pkg::csr_pmpaddr_base : csr_pkg::csr_pmpaddr_limit],
            [csr_pkg::csr_mhpmcounter_base : csr_pkg::csr_mhpmcounter_limit],
            [csr_pkg::csr_mhpmcounterh_base : csr_pkg::csr_mhpmcounterh_limit]: begin
                const_value = '0;
            end
            default: begin
                const_value = '0;  // unlisted, still predictable
            end
        endcase
    end

    // register blocks win over the constant space
    always_comb begin
        if (bus.trap_hit) begin
            read_value = bus.trap_rdata;
        end else if (bus.count_hit) begin
            read_value = bus.count_rdata;
        end else begin
            read_value = const_value;
        end
    end

    always_comb begin
        case (op)
            csr_pkg::csr_op_rw: new_value = operand;
            csr_pkg::csr_op_rs: new_value = read_value | operand;
            csr_pkg::csr_op_rc: new_value = read_value & ~operand;
            default:            new_value = read_value;  // no change
        endcase
    end

    assign bus.addr    = csr;
    assign bus.wr_data = new_value;
    assign bus.wr_en   = write && !stall && !flush;

endmodule

`default_nettype wire

// File: hdl/csr_bus_if.sv
`default_nettype none

interface csr_bus_if;

    csr_pkg::csr_addr_t addr;
    logic               wr_en;  // one-cycle strobe, already gated
    csr_pkg::csr_word_t wr_data;

    logic               trap_hit;
    csr_pkg::csr_word_t trap_rdata;
    logic               count_hit;
    csr_pkg::csr_word_t count_rdata;

    modport access (
        output addr, wr_en, wr_data,
        input  trap_hit, trap_rdata, count_hit, count_rdata
    );

    modport trap (
        input  addr, wr_en, wr_data,
        output trap_hit, trap_rdata
    );

    // counters are read-only here
    modport counter (
        input  addr,
        output count_hit, count_rdata
    );

endinterface

`default_nettype wire

// File: hdl/csr_counters.sv
`default_nettype none

module csr_counters (
    input  logic                clk,
    input  logic                reset,
    input  logic                retired,
    input  logic                wb_flush,
    output csr_pkg::csr_count_t cycle_count,
    csr_bus_if.counter          bus
);

    csr_pkg::csr_count_t cycle_q;
    csr_pkg::csr_count_t instret_q;

    logic               hit;
    csr_pkg::csr_word_t rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
            if (retired && !wb_flush) begin
                instret_q <= instret_q + 64'd1;  // flushed retires don't count
            end
        end
    end

    assign cycle_count = cycle_q;

    // time has no separate timer, shares the cycle count
    always_comb begin
        hit = 1'b1;
        case (bus.addr)
            csr_pkg::csr_mcycle,
            csr_pkg::csr_cycle,
            csr_pkg::csr_time:      rdata = cycle_q[31:0];
            csr_pkg::csr_mcycleh,
            csr_pkg::csr_cycleh,
            csr_pkg::csr_timeh:     rdata = cycle_q[63:32];
            csr_pkg::csr_minstret,
            csr_pkg::csr_instret:   rdata = instret_q[31:0];
            csr_pkg::csr_minstreth,
            csr_pkg::csr_instreth:  rdata = instret_q[63:32];
            default: begin
                hit   = 1'b0;
                rdata = '0;
            end
        endcase
    end

    assign bus.count_hit   = hit;
    assign bus.count_rdata = rdata;

endmodule

`default_nettype wire

// File: hdl/csr_file.sv
`default_nettype none

module csr_file #(
    parameter csr_pkg::csr_word_t HART_ID = 32'd0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                flush,
    input  logic                wb_flush,
    input  logic                read,  // reads have no side effects
    input  logic                write,
    input  logic                retired,
    input  csr_pkg::csr_op_e    op,
    input  csr_pkg::csr_src_e   src,
    input  csr_pkg::csr_addr_t  csr,
    input  csr_pkg::csr_word_t  rs1_value,
    input  csr_pkg::csr_word_t  imm_value,
    output csr_pkg::csr_word_t  read_value,
    output csr_pkg::csr_count_t cycle_count
);

    csr_bus_if bus ();

    // operand, op and gating, plus the constant read space
    csr_access #(
        .HART_ID (HART_ID)
    ) csr_access_inst (
        .stall      (stall),
        .flush      (flush),
        .write      (write),
        .op         (op),
        .src        (src),
        .csr        (csr),
        .rs1_value  (rs1_value),
        .imm_value  (imm_value),
        .read_value (read_value),
        .bus        (bus.access)
    );

    csr_trap_regs csr_trap_regs_inst (
        .clk   (clk),
        .reset (reset),
        .bus   (bus.trap)
    );

    csr_counters csr_counters_inst (
        .clk         (clk),
        .reset       (reset),
        .retired     (retired),
        .wb_flush    (wb_flush),
        .cycle_count (cycle_count),  // straight to the core
        .bus         (bus.counter)
    );

endmodule

`default_nettype wire

// File: hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_word_t;
    typedef logic [63:0] csr_count_t;

    typedef enum logic [1:0] {
        csr_op_rw = 2'b00,
        csr_op_rs = 2'b01,
        csr_op_rc = 2'b10
    } csr_op_e;

    typedef enum logic {
        csr_src_imm = 1'b0,
        csr_src_reg = 1'b1
    } csr_src_e;

    // machine trap setup and handling
    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_misa     = 12'h301;
    localparam csr_addr_t csr_mie      = 12'h304;
    localparam csr_addr_t csr_mtvec    = 12'h305;
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mtval    = 12'h343;
    localparam csr_addr_t csr_mip      = 12'h344;

    // counters and user aliases
    localparam csr_addr_t csr_mcycle    = 12'hb00;
    localparam csr_addr_t csr_minstret  = 12'hb02;
    localparam csr_addr_t csr_mcycleh   = 12'hb80;
    localparam csr_addr_t csr_minstreth = 12'hb82;
    localparam csr_addr_t csr_cycle     = 12'hc00;
    localparam csr_addr_t csr_time      = 12'hc01;
    localparam csr_addr_t csr_instret   = 12'hc02;
    localparam csr_addr_t csr_cycleh    = 12'hc80;
    localparam csr_addr_t csr_timeh     = 12'hc81;
    localparam csr_addr_t csr_instreth  = 12'hc82;

    localparam csr_addr_t csr_mvendorid = 12'hf11;
    localparam csr_addr_t csr_marchid   = 12'hf12;
    localparam csr_addr_t csr_mimpid    = 12'hf13;
    localparam csr_addr_t csr_mhartid   = 12'hf14;

    // zero-reading ranges, limits inclusive
    localparam csr_addr_t csr_mhpmevent_base    = 12'h323;
    localparam csr_addr_t csr_mhpmevent_limit   = 12'h33f;
    localparam csr_addr_t csr_pmpcfg_base       = 12'h3a0;
    localparam csr_addr_t csr_pmpcfg_limit      = 12'h3a3;
    localparam csr_addr_t csr_pmpaddr_base      = 12'h3b0;
    localparam csr_addr_t csr_pmpaddr_limit     = 12'h3bf;
    localparam csr_addr_t csr_mhpmcounter_base  = 12'hb03;
    localparam csr_addr_t csr_mhpmcounter_limit = 12'hb1f;
    localparam csr_addr_t csr_mhpmcounterh_base  = 12'hb83;
    localparam csr_addr_t csr_mhpmcounterh_limit = 12'hb9f;

    localparam csr_word_t misa_value = 32'h4000_0100;  // mxl=1, I only

    localparam int mie_bit  = 3;  // mstatus
    localparam int mpie_bit = 7;  // mstatus
    localparam int msie_bit = 3;
    localparam int mtie_bit = 7;
    localparam int meie_bit = 11;

    localparam logic [1:0] mstatus_mpp_machine = 2'b11;

    // full mcause words, interrupt flag in bit 31
    typedef enum logic [31:0] {
        mcause_instr_misaligned = 32'h0000_0000,
        mcause_instr_fault      = 32'h0000_0001,
        mcause_illegal_instr    = 32'h0000_0002,
        mcause_breakpoint       = 32'h0000_0003,
        mcause_load_misaligned  = 32'h0000_0004,
        mcause_load_fault       = 32'h0000_0005,
        mcause_store_misaligned = 32'h0000_0006,
        mcause_store_fault      = 32'h0000_0007,
        mcause_ecall_m          = 32'h0000_000b,
        mcause_msoft_irq        = 32'h8000_0003,
        mcause_mtimer_irq       = 32'h8000_0007,
        mcause_mext_irq         = 32'h8000_000b
    } mcause_code_e;

endpackage

`default_nettype wire

// File: hdl/csr_trap_regs.sv
`default_nettype none

module csr_trap_regs (
    input logic     clk,
    input logic     reset,
    csr_bus_if.trap bus
);

    logic               mstatus_mie;
    logic               mstatus_mpie;
    logic               mie_msie;
    logic               mie_mtie;
    logic               mie_meie;
    logic [31:2]        mtvec_base;
    logic               mtvec_mode;  // bit 1 reserved
    csr_pkg::csr_word_t mscratch;
    logic [31:2]        mepc;
    logic               mcause_irq;
    logic [3:0]         mcause_code;
    csr_pkg::csr_word_t mtval;

    logic               hit;
    csr_pkg::csr_word_t rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec_base   <= '0;
            mtvec_mode   <= 1'b0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_irq   <= 1'b0;
            mcause_code  <= '0;
            mtval        <= '0;
        end else if (bus.wr_en) begin
            case (bus.addr)
                csr_pkg::csr_mstatus: begin
                    mstatus_mie  <= bus.wr_data[csr_pkg::mie_bit];
                    mstatus_mpie <= bus.wr_data[csr_pkg::mpie_bit];
                end
                csr_pkg::csr_mie: begin
                    mie_msie <= bus.wr_data[csr_pkg::msie_bit];
                    mie_mtie <= bus.wr_data[csr_pkg::mtie_bit];
                    mie_meie <= bus.wr_data[csr_pkg::meie_bit];
                end
                csr_pkg::csr_mtvec: begin
                    mtvec_base <= bus.wr_data[31:2];
                    mtvec_mode <= bus.wr_data[0];
                end
                csr_pkg::csr_mscratch: mscratch <= bus.wr_data;
                csr_pkg::csr_mepc:     mepc <= bus.wr_data[31:2];
                csr_pkg::csr_mcause: begin
                    mcause_irq  <= bus.wr_data[31];
                    mcause_code <= bus.wr_data[3:0];
                end
                csr_pkg::csr_mtval:    mtval <= bus.wr_data;
                default: ;
            endcase
        end
    end

    // pack fields back into place
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (bus.addr)
            csr_pkg::csr_mstatus: begin
                rdata[csr_pkg::mie_bit]  = mstatus_mie;
                rdata[csr_pkg::mpie_bit] = mstatus_mpie;
                rdata[12:11]             = csr_pkg::mstatus_mpp_machine;  // mpp
            end
            csr_pkg::csr_mie: begin
                rdata[csr_pkg::msie_bit] = mie_msie;
                rdata[csr_pkg::mtie_bit] = mie_mtie;
                rdata[csr_pkg::meie_bit] = mie_meie;
            end
            csr_pkg::csr_mtvec:    rdata = {mtvec_base, 1'b0, mtvec_mode};
            csr_pkg::csr_mscratch: rdata = mscratch;
            csr_pkg::csr_mepc:     rdata = {mepc, 2'b00};
            csr_pkg::csr_mcause:   rdata = {mcause_irq, 27'd0, mcause_code};
            csr_pkg::csr_mtval:    rdata = mtval;
            default:               hit = 1'b0;
        endcase
    end

    assign bus.trap_hit   = hit;
    assign bus.trap_rdata = rdata;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the csr_file testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
log=build/sim.log
mkdir -p build \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module csr_file_tb -Mdir build -f csr_file.f \
    && { ./build/Vcsr_file_tb > "$log" 2>&1 || true; } \
    && cat "$log" \
    && ! grep -q "test failed" "$log" \
    && grep -q "test passed" "$log" \
    || { echo "simulation failed"; exit 1; }
echo "simulation ok"

// File: sim/csr_file_properties.sv
`default_nettype none

module csr_file_properties (
    input logic                clk,
    input logic                reset,
    input logic                stall,
    input logic                flush,
    input logic                wb_flush,
    input logic [134:0]        trap_state,
    input csr_pkg::csr_count_t cycle_count,
    input csr_pkg::csr_count_t instret
);

    timeunit 1ns;
    timeprecision 1ps;

    // a stalled or flushed access leaves every trap field as it was
    write_dropped: assert property (@(posedge clk) disable iff (reset)
        (stall || flush) |=> $stable(trap_state))
        else $error("trap register changed during stall or flush");

    cycle_steps: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> cycle_count == $past(cycle_count) + 64'd1)
        else $error("cycle counter did not advance by exactly one");

    instret_held: assert property (@(posedge clk) disable iff (reset)
        ($past(wb_flush) && !$past(reset)) |-> instret == $past(instret))
        else $error("retired-instruction counter moved under writeback flush");

endmodule

bind csr_file csr_file_properties csr_file_properties_inst (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .flush       (flush),
    .wb_flush    (wb_flush),
    .trap_state  ({csr_trap_regs_inst.mstatus_mie, csr_trap_regs_inst.mstatus_mpie,
                   csr_trap_regs_inst.mie_msie, csr_trap_regs_inst.mie_mtie,
                   csr_trap_regs_inst.mie_meie, csr_trap_regs_inst.mtvec_base,
                   csr_trap_regs_inst.mtvec_mode, csr_trap_regs_inst.mscratch,
                   csr_trap_regs_inst.mepc, csr_trap_regs_inst.mcause_irq,
                   csr_trap_regs_inst.mcause_code, csr_trap_regs_inst.mtval}),
    .cycle_count (cycle_count),
    .instret     (csr_counters_inst.instret_q)
);

`default_nettype wire

// File: sim/csr_file_tb.sv
`default_nettype none

module csr_file_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam csr_pkg::csr_word_t hart_id = 32'd3;
    localparam int timeout_cycles = 50;

    typedef struct {
        csr_pkg::csr_op_e   op;
        csr_pkg::csr_src_e  src;
        csr_pkg::csr_addr_t addr;
        csr_pkg::csr_word_t rs1;
        csr_pkg::csr_word_t imm;
        logic               stall;
        logic               flush;
        csr_pkg::csr_word_t expected;
    } stim_t;

    logic                clk;
    logic                reset;
    logic                stall;
    logic                flush;
    logic                wb_flush;
    logic                read;
    logic                write;
    logic                retired;
    csr_pkg::csr_op_e    op;
    csr_pkg::csr_src_e   src;
    csr_pkg::csr_addr_t  csr;
    csr_pkg::csr_word_t  rs1_value;
    csr_pkg::csr_word_t  imm_value;
    csr_pkg::csr_word_t  read_value;
    csr_pkg::csr_count_t cycle_count;

    int                  seed;
    stim_t               table_q[$];
    csr_pkg::csr_word_t  model_regs [0:4095];  // writable bits only
    csr_pkg::csr_count_t expected_cycles;

    csr_file #(
        .HART_ID (hart_id)
    ) csr_file_inst (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .flush       (flush),
        .wb_flush    (wb_flush),
        .read        (read),
        .write       (write),
        .retired     (retired),
        .op          (op),
        .src         (src),
        .csr         (csr),
        .rs1_value   (rs1_value),
        .imm_value   (imm_value),
        .read_value  (read_value),
        .cycle_count (cycle_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            expected_cycles <= '0;
        end else begin
            expected_cycles <= expected_cycles + 64'd1;
        end
    end

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input csr_pkg::csr_word_t actual,
                              input csr_pkg::csr_word_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 32'h%h, expected 32'h%h", name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input csr_pkg::csr_count_t actual,
                               input csr_pkg::csr_count_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 64'h%h, expected 64'h%h", name, actual, expected);
            stop_run();
        end
    endtask

    function automatic csr_pkg::csr_word_t rand_word();
        return csr_pkg::csr_word_t'($random(seed));
    endfunction

    function automatic csr_pkg::csr_word_t writable_mask(input csr_pkg::csr_addr_t addr);
        csr_pkg::csr_word_t mask;
        mask = '0;
        case (addr)
            csr_pkg::csr_mstatus: begin
                mask[csr_pkg::mie_bit]  = 1'b1;
                mask[csr_pkg::mpie_bit] = 1'b1;
            end
            csr_pkg::csr_mie: begin
                mask[csr_pkg::msie_bit] = 1'b1;
                mask[csr_pkg::mtie_bit] = 1'b1;
                mask[csr_pkg::meie_bit] = 1'b1;
            end
            csr_pkg::csr_mtvec:    mask = 32'hffff_fffd;
            csr_pkg::csr_mscratch: mask = 32'hffff_ffff;
            csr_pkg::csr_mtval:    mask = 32'hffff_ffff;
            csr_pkg::csr_mepc:     mask = 32'hffff_fffc;
            csr_pkg::csr_mcause:   mask = 32'h8000_000f;  // irq flag and 4-bit code
            default:               mask = '0;
        endcase
        return mask;
    endfunction

    // bits that read back regardless of writes
    function automatic csr_pkg::csr_word_t fixed_bits(input csr_pkg::csr_addr_t addr);
        csr_pkg::csr_word_t bits;
        bits = '0;
        case (addr)
            csr_pkg::csr_mstatus: bits = csr_pkg::csr_word_t'(csr_pkg::mstatus_mpp_machine) << 11;
            csr_pkg::csr_misa:    bits = csr_pkg::misa_value;
            csr_pkg::csr_mhartid: bits = hart_id;
            default:              bits = '0;
        endcase
        return bits;
    endfunction

    // value goes to the selected source, the other operand gets noise
    task automatic add_entry(input csr_pkg::csr_op_e op_in, input csr_pkg::csr_src_e src_in,
                             input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t value,
                             input logic stall_in, input logic flush_in);
        stim_t              e;
        csr_pkg::csr_word_t old_value;
        csr_pkg::csr_word_t new_value;
        old_value = model_regs[addr] | fixed_bits(addr);
        case (op_in)
            csr_pkg::csr_op_rs: new_value = old_value | value;
            csr_pkg::csr_op_rc: new_value = old_value & ~value;
            default:            new_value = value;
        endcase
        if (!stall_in && !flush_in) begin
            model_regs[addr] = new_value & writable_mask(addr);
        end
        e.op       = op_in;
        e.src      = src_in;
        e.addr     = addr;
        e.rs1      = (src_in == csr_pkg::csr_src_reg) ? value : rand_word();
        e.imm      = (src_in == csr_pkg::csr_src_imm) ? value : (rand_word() & 32'h1f);
        e.stall    = stall_in;
        e.flush    = flush_in;
        e.expected = model_regs[addr] | fixed_bits(addr);
        table_q.push_back(e);
    endtask

    task automatic build_table();
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mscratch, rand_word(), 0, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mtval, rand_word(), 0, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_imm, csr_pkg::csr_mscratch, 32'h15, 0, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mepc,
                  rand_word() | 32'h3, 0, 0);  // low bits set so the clear shows
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mtvec, 32'hffff_ffff, 0, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mtvec, rand_word(), 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_reg, csr_pkg::csr_mstatus, 32'hffff_ffff, 0, 0);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_imm, csr_pkg::csr_mstatus, 32'h08, 0, 0);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_reg, csr_pkg::csr_mstatus, rand_word(), 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_imm, csr_pkg::csr_mstatus, 32'h0c, 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_reg, csr_pkg::csr_mie, rand_word(), 0, 0);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_imm, csr_pkg::csr_mie, 32'h08, 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_reg, csr_pkg::csr_mie, 32'h0000_0888, 0, 0);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_reg, csr_pkg::csr_mie, 32'h0000_0800, 0, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mcause,
                  csr_pkg::csr_word_t'(csr_pkg::mcause_mtimer_irq), 0, 0);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_reg, csr_pkg::csr_mcause, 32'h8000_0000, 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_imm, csr_pkg::csr_mcause,
                  csr_pkg::csr_word_t'(csr_pkg::mcause_ecall_m), 0, 0);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_imm, csr_pkg::csr_mcause, 32'h05, 0, 0);
        // stall and flush drop the write
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mscratch, rand_word(), 1, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mtval, rand_word(), 0, 1);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_reg, csr_pkg::csr_mie, 32'hffff_ffff, 1, 1);
        add_entry(csr_pkg::csr_op_rc, csr_pkg::csr_src_reg, csr_pkg::csr_mstatus, 32'hffff_ffff, 0, 1);
        // constant space ignores writes
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_misa, rand_word(), 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_imm, csr_pkg::csr_mhartid, 32'h1f, 0, 0);
        add_entry(csr_pkg::csr_op_rs, csr_pkg::csr_src_reg, 12'h325, rand_word(), 0, 0);  // mhpmevent5
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, 12'h3b4, rand_word(), 0, 0);  // pmpaddr4
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, csr_pkg::csr_mip, 32'hffff_ffff, 0, 0);
        add_entry(csr_pkg::csr_op_rw, csr_pkg::csr_src_reg, 12'h7c0, rand_word(), 0, 0);  // unlisted
    endtask

    // write on one edge, check the read after the next
    task automatic apply_table();
        foreach (table_q[i]) begin
            @(posedge clk);
            op        <= table_q[i].op;
            src       <= table_q[i].src;
            csr       <= table_q[i].addr;
            rs1_value <= table_q[i].rs1;
            imm_value <= table_q[i].imm;
            stall     <= table_q[i].stall;
            flush     <= table_q[i].flush;
            write     <= 1'b1;
            @(posedge clk);
            write <= 1'b0;
            stall <= 1'b0;
            flush <= 1'b0;
            @(negedge clk);
            check_word($sformatf("read_value entry %0d", i), read_value, table_q[i].expected);
        end
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_word_t value);
        @(posedge clk);
        csr <= addr;
        @(negedge clk);
        value = read_value;
    endtask

    task automatic wait_until_counting();
        int waited;
        waited = 0;
        while (cycle_count == 64'd0 && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (cycle_count == 64'd0) begin
            $display("timeout: cycle counter never started after reset");
            stop_run();
        end
    endtask

    task automatic check_counters();
        csr_pkg::csr_word_t first;
        csr_pkg::csr_word_t second;
        int                 gap;
        gap = 4 + int'(rand_word() & 32'h7);
        read_csr(csr_pkg::csr_mcycle, first);
        check_count("cycle_count", cycle_count, expected_cycles);
        check_word("mcycle", first, expected_cycles[31:0]);
        repeat (gap - 1) @(posedge clk);
        read_csr(csr_pkg::csr_mcycle, second);
        check_word("mcycle delta", second - first, csr_pkg::csr_word_t'(gap));
        read_csr(csr_pkg::csr_cycle, second);
        check_word("cycle", second, expected_cycles[31:0]);
        read_csr(csr_pkg::csr_time, second);
        check_word("time", second, expected_cycles[31:0]);
        read_csr(csr_pkg::csr_mcycleh, second);
        check_word("mcycleh", second, expected_cycles[63:32]);
        check_count("cycle_count", cycle_count, expected_cycles);
        read_csr(csr_pkg::csr_cycleh, second);
        check_word("cycleh", second, expected_cycles[63:32]);
    endtask

    task automatic check_retired();
        int                 unflushed;
        int                 i;
        csr_pkg::csr_word_t noise;
        csr_pkg::csr_word_t value;
        unflushed = 0;
        for (i = 0; i < 16; i++) begin
            noise = rand_word();
            @(posedge clk);
            retired  <= noise[0] | noise[1];  // mostly pulses, a few idle cycles
            wb_flush <= noise[2];
            if ((noise[0] | noise[1]) && !noise[2]) begin
                unflushed++;
            end
        end
        @(posedge clk);
        retired  <= 1'b0;
        wb_flush <= 1'b0;
        read_csr(csr_pkg::csr_minstret, value);
        check_word("minstret", value, csr_pkg::csr_word_t'(unflushed));
        read_csr(csr_pkg::csr_instret, value);
        check_word("instret", value, csr_pkg::csr_word_t'(unflushed));
        read_csr(csr_pkg::csr_minstreth, value);
        check_word("minstreth", value, '0);
    endtask

    initial begin
        seed      = 32'h54db;
        reset     = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        wb_flush  = 1'b0;
        read      = 1'b1;
        write     = 1'b0;
        retired   = 1'b0;
        op        = csr_pkg::csr_op_rw;
        src       = csr_pkg::csr_src_reg;
        csr       = '0;
        rs1_value = '0;
        imm_value = '0;
        foreach (model_regs[a]) begin
            model_regs[a] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_count("cycle_count", cycle_count, 64'd0);
        wait_until_counting();
        build_table();
        apply_table();
        check_counters();
        check_retired();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
